// ==== hdl/age_pipe_pkg.sv ====
package age_pipe_pkg;

    // Payload width of every item
    localparam int DATA_W = 16;

    // Age counter width, counts saturate at AGE_MAX
    localparam int AGE_W = 8;
    localparam logic [AGE_W-1:0] AGE_MAX = {AGE_W{1'b1}};

    // One item as it travels down the chain
    typedef struct packed {
        logic [DATA_W-1:0] payload;
        logic [AGE_W-1:0]  age;
    } age_item_t;

    // Saturating age increment
    // An item that reached AGE_MAX stays there and never wraps back to young
    function automatic logic [AGE_W-1:0] age_inc(input logic [AGE_W-1:0] age);
        logic [AGE_W-1:0] next_age;
        if (age == AGE_MAX) begin
            next_age = age;
        end else begin
            next_age = age + 1'b1;
        end
        return next_age;
    endfunction

endpackage

// ==== hdl/skid_stage.sv ====
`timescale 1ns/100ps

// Two-entry buffered handshake stage
// Main entry feeds the output, extra entry catches an item when main is stuck
// Every held item gets one year older per clock
module skid_stage
    import age_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Upstream side
    input  age_item_t up_item,
    input  logic      up_valid,
    output logic      up_ready,

    // Downstream side
    output age_item_t dn_item,
    output logic      dn_valid,
    input  logic      dn_ready
);

    // Main entry, always the one presented downstream
    age_item_t main_item;
    logic      main_valid;

    // Extra entry, only used while main is full and stalled
    age_item_t extra_item;
    logic      extra_valid;

    // Handshake helpers
    logic      shift_in;
    logic      shift_out;
    logic      main_free;
    logic      main_en;
    logic      extra_en;

    // Source for a main entry load
    age_item_t refill_item;

    // Ready only depends on state here, high while the extra entry is empty
    assign up_ready  = !extra_valid;

    assign shift_in  = up_valid && up_ready;
    assign shift_out = main_valid && dn_ready;

    // Main can take a new item if empty or emptying this cycle
    assign main_free = !main_valid || shift_out;

    // Extra entry always has priority, it holds the older item
    assign main_en     = main_free && (extra_valid || shift_in);
    assign refill_item = extra_valid ? extra_item : up_item;

    // Park the incoming item when main is occupied and not draining
    assign extra_en = shift_in && main_valid && !shift_out;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid  <= 1'b0;
            extra_valid <= 1'b0;
        end else begin
            if (main_en) begin
                main_valid <= 1'b1;
            end else if (shift_out) begin
                main_valid <= 1'b0;
            end

            // A drain with extra full always refills main from extra
            if (extra_en) begin
                extra_valid <= 1'b1;
            end else if (shift_out) begin
                extra_valid <= 1'b0;
            end
        end
    end

    // Main entry payload and age
    // The capture edge itself counts as one cycle of age
    always_ff @(posedge clk) begin
        if (main_en) begin
            main_item.payload <= refill_item.payload;
            main_item.age     <= age_inc(refill_item.age);
        end else if (main_valid) begin
            // Still waiting, keep aging
            main_item.age <= age_inc(main_item.age);
        end
    end

    // Extra entry payload and age
    always_ff @(posedge clk) begin
        if (extra_en) begin
            extra_item.payload <= up_item.payload;
            extra_item.age     <= age_inc(up_item.age);
        end else if (extra_valid) begin
            extra_item.age <= age_inc(extra_item.age);
        end
    end

    // Output straight from the main entry
    assign dn_item  = main_item;
    assign dn_valid = main_valid;

endmodule

// ==== hdl/age_limit_filter.sv ====
`timescale 1ns/100ps

// Age filter at the end of the chain
// Young items pass through untouched, over-age items are swallowed
// Purely combinational on the item path
module age_limit_filter
    import age_pipe_pkg::*;
#(
    // Largest age still forwarded
    parameter int AGE_LIMIT = 12
) (
    input  logic        clk,
    input  logic        rst,

    // From the last skid stage
    input  age_item_t   in_item,
    input  logic        in_valid,
    output logic        in_ready,

    // To the outside
    output age_item_t   out_item,
    output logic        out_valid,
    input  logic        out_ready,

    // Number of items thrown away
    output logic [15:0] drop_count
);

    // Limit at the age width, clipped so a huge limit just never drops
    localparam logic [AGE_W-1:0] LIMIT =
        (AGE_LIMIT >= int'(AGE_MAX)) ? AGE_MAX : AGE_W'(AGE_LIMIT);

    logic too_old;
    logic drop;

    assign too_old = in_item.age > LIMIT;

    // Over-age items are never shown downstream
    assign out_item  = in_item;
    assign out_valid = in_valid && !too_old;

    // Stale items are consumed right away, regardless of out_ready
    assign in_ready  = too_old || out_ready;

    // Item consumed without being delivered
    assign drop = in_valid && too_old;

    // Saturating drop counter
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (drop && (drop_count != 16'hffff)) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

// ==== hdl/delivery_stats.sv ====
`timescale 1ns/100ps

// Output statistics
// Passive observer of the output handshake, drives nothing on the item path
module delivery_stats
    import age_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    // Observed output port
    input  age_item_t        item,
    input  logic             valid,
    input  logic             ready,

    // Items delivered so far
    output logic [15:0]      delivered_count,
    // Oldest age ever delivered
    output logic [AGE_W-1:0] max_age
);

    logic fire;

    // One transfer per edge with both valid and ready high
    assign fire = valid && ready;

    // Delivered count, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            delivered_count <= '0;
        end else if (fire && (delivered_count != 16'hffff)) begin
            delivered_count <= delivered_count + 16'd1;
        end
    end

    // Running maximum of the delivered age
    always_ff @(posedge clk) begin
        if (rst) begin
            max_age <= '0;
        end else if (fire && (item.age > max_age)) begin
            max_age <= item.age;
        end
    end

endmodule

// ==== hdl/age_pipe_top.sv ====
`timescale 1ns/100ps

// Age-tracking elastic pipeline
// NUM_STAGES skid stages, then the age filter, with stats on the output port
module age_pipe_top
    import age_pipe_pkg::*;
#(
    // Depth of the skid chain, 1 to 8
    parameter int NUM_STAGES = 3,
    // Largest age the filter lets through
    parameter int AGE_LIMIT  = 12
) (
    input  logic             clk,
    input  logic             rst,

    // Input port, items arrive with age 0
    input  age_item_t        in_item,
    input  logic             in_valid,
    output logic             in_ready,

    // Output port after the filter
    output age_item_t        out_item,
    output logic             out_valid,
    input  logic             out_ready,

    // Status
    output logic [15:0]      drop_count,
    output logic [15:0]      delivered_count,
    output logic [AGE_W-1:0] max_age
);

    // Links between stages
    // Index 0 is the input port, index NUM_STAGES feeds the filter
    age_item_t               chain_item [NUM_STAGES+1];
    logic [NUM_STAGES:0]     chain_valid;
    logic [NUM_STAGES:0]     chain_ready;

    // Head of the chain
    assign chain_item[0]  = in_item;
    assign chain_valid[0] = in_valid;
    assign in_ready       = chain_ready[0];

    // Skid chain
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        skid_stage u_stage (
            .clk      (clk),
            .rst      (rst),
            .up_item  (chain_item[k]),
            .up_valid (chain_valid[k]),
            .up_ready (chain_ready[k]),
            .dn_item  (chain_item[k+1]),
            .dn_valid (chain_valid[k+1]),
            .dn_ready (chain_ready[k+1])
        );
    end

    // Drop stale items at the tail
    age_limit_filter #(
        .AGE_LIMIT (AGE_LIMIT)
    ) u_filter (
        .clk        (clk),
        .rst        (rst),
        .in_item    (chain_item[NUM_STAGES]),
        .in_valid   (chain_valid[NUM_STAGES]),
        .in_ready   (chain_ready[NUM_STAGES]),
        .out_item   (out_item),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .drop_count (drop_count)
    );

    // Watch what actually leaves the pipeline
    delivery_stats u_stats (
        .clk             (clk),
        .rst             (rst),
        .item            (out_item),
        .valid           (out_valid),
        .ready           (out_ready),
        .delivered_count (delivered_count),
        .max_age         (max_age)
    );

endmodule

// ==== test/age_pipe_tb.sv ====
`timescale 1ns/100ps

// Self-checking testbench for the age-tracking pipeline
// Inputs change on the falling edge, outputs are sampled there too
module age_pipe_tb
    import age_pipe_pkg::*;
();

    localparam int NUM_STAGES = 3;
    localparam int AGE_LIMIT  = 12;
    localparam int NUM_ROWS   = 5;

    // How out_ready behaves during a row
    localparam logic [1:0] MODE_ALWAYS = 2'd0;
    localparam logic [1:0] MODE_RANDOM = 2'd1;
    localparam logic [1:0] MODE_HOLD   = 2'd2;

    // What a row should end with
    localparam logic [1:0] EXP_CLEAN = 2'd0;
    localparam logic [1:0] EXP_FULL  = 2'd1;
    localparam logic [1:0] EXP_DROP  = 2'd2;

    // One scenario row
    typedef struct packed {
        logic [15:0] count;
        logic [15:0] base;
        logic [1:0]  mode;
        logic [7:0]  hold;
        logic [1:0]  outcome;
    } row_t;

    // Scoreboard entry, payload plus the edge it went in on
    typedef struct packed {
        logic [DATA_W-1:0] payload;
        logic [31:0]       cyc;
    } sent_t;

    logic             clk;
    logic             rst;
    age_item_t        in_item;
    logic             in_valid;
    logic             in_ready;
    age_item_t        out_item;
    logic             out_valid;
    logic             out_ready;
    logic [15:0]      drop_count;
    logic [15:0]      delivered_count;
    logic [AGE_W-1:0] max_age;

    sent_t            sent_q [$];
    // Number of the rising edge that follows the current falling edge
    int               cyc;
    int               drops_seen;
    int               total_delivered;
    logic [AGE_W-1:0] max_seen;

    age_pipe_top #(
        .NUM_STAGES (NUM_STAGES),
        .AGE_LIMIT  (AGE_LIMIT)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .in_item         (in_item),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .out_item        (out_item),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .drop_count      (drop_count),
        .delivered_count (delivered_count),
        .max_age         (max_age)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Scenario table: count, payload base, out_ready mode, hold cycles, outcome
    function automatic row_t table_row(input int idx);
        row_t r;
        case (idx)
            0: r = {16'd16, 16'h1000, MODE_ALWAYS, 8'd0, EXP_CLEAN};
            1: r = {16'd40, 16'h2000, MODE_RANDOM, 8'd0, EXP_CLEAN};
            // Short hold, chain fills but nothing gets too old
            2: r = {16'd8, 16'h3000, MODE_HOLD, 8'd8, EXP_FULL};
            // Long hold, the oldest items must be dropped
            3: r = {16'd12, 16'h4000, MODE_HOLD, 8'd20, EXP_DROP};
            4: r = {16'd10, 16'h5000, MODE_ALWAYS, 8'd0, EXP_CLEAN};
            default: r = '0;
        endcase
        return r;
    endfunction

    // Cycle budget grows with items, depth and stall time
    function automatic int timeout_limit();
        int   total;
        row_t r;
        total = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = table_row(i);
            total += int'(r.count) * (NUM_STAGES + int'(r.hold) + 4);
        end
        return total;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_item(input age_item_t got, input age_item_t exp, input string name);
        if (got !== exp) begin
            $display("ERR %s expected 0x%06h actual 0x%06h", name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp,
                               input string name);
        if (got !== exp) begin
            $display("ERR %s expected 0x%04h actual 0x%04h", name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cyc++;
    endtask

    // Items dropped by the filter leave the front of the scoreboard in order
    task automatic absorb_drops();
        sent_t ent;
        while (drops_seen < int'(drop_count)) begin
            if (sent_q.size() == 0) begin
                $display("Filter reports more drops than items were sent");
                stop_with_failure();
            end else begin
                ent = sent_q.pop_front();
                drops_seen++;
            end
        end
    endtask

    // Called when out_valid and out_ready are both high before the next edge
    task automatic handle_delivery(input logic free_flow);
        sent_t     ent;
        age_item_t exp;
        int        diff;
        absorb_drops();
        if (sent_q.size() == 0) begin
            $display("Output delivered an item that was never sent");
            stop_with_failure();
        end else begin
            ent = sent_q.pop_front();
            // Age counts every edge from capture up to the one before delivery
            diff = cyc - int'(ent.cyc);
            exp.payload = ent.payload;
            if (free_flow) begin
                exp.age = AGE_W'(NUM_STAGES);
            end else if (diff > int'(AGE_MAX)) begin
                exp.age = AGE_MAX;
            end else begin
                exp.age = AGE_W'(diff);
            end
            check_item(out_item, exp, "out_item");
            if ((int'(out_item.age) < NUM_STAGES) || (int'(out_item.age) > AGE_LIMIT)) begin
                $display("Delivered age %0d is outside the allowed range", out_item.age);
                stop_with_failure();
            end else begin
                total_delivered++;
                if (out_item.age > max_seen) begin
                    max_seen = out_item.age;
                end
            end
        end
    endtask

    task automatic run_row(input row_t r);
        int          sent;
        int          delivered;
        int          dropped;
        int          drop_base;
        int          dc_base;
        int          row_cyc;
        logic        ready_prev;
        logic        full_seen;
        logic        take_pending;
        logic [31:0] rnd;
        sent_t       ent;
        sent = 0;
        delivered = 0;
        dropped = 0;
        drop_base = int'(drop_count);
        dc_base = int'(delivered_count);
        row_cyc = 0;
        ready_prev = 1'b1;
        full_seen = 1'b0;
        take_pending = 1'b0;
        while ((sent < int'(r.count)) || (delivered + dropped < int'(r.count))) begin
            tick();
            dropped = int'(drop_count) - drop_base;
            // Previous item went in on the last rising edge
            if (take_pending) begin
                in_valid = 1'b0;
                take_pending = 1'b0;
            end
            case (r.mode)
                MODE_RANDOM: begin
                    // Never low two cycles running
                    rnd = $urandom;
                    out_ready = ready_prev ? rnd[0] : 1'b1;
                end
                MODE_HOLD: out_ready = (row_cyc >= int'(r.hold));
                default:   out_ready = 1'b1;
            endcase
            ready_prev = out_ready;
            // Random rows keep at most two items in flight so nothing ages out
            if (!in_valid && (sent < int'(r.count))) begin
                if ((r.mode != MODE_RANDOM) || (sent - delivered - dropped < 2)) begin
                    in_item.payload = r.base + DATA_W'(sent);
                    in_item.age = '0;
                    in_valid = 1'b1;
                end
            end
            // First stall on the input while the output is held
            if ((r.outcome == EXP_FULL) && !full_seen && in_valid && !in_ready && !out_ready) begin
                full_seen = 1'b1;
                check_count(16'(sent), 16'(2 * NUM_STAGES), "accepted_before_full");
            end
            if (out_valid && out_ready) begin
                handle_delivery(r.mode == MODE_ALWAYS);
                delivered++;
            end
            if (in_valid && in_ready) begin
                ent.payload = in_item.payload;
                ent.cyc = 32'(cyc);
                sent_q.push_back(ent);
                sent++;
                take_pending = 1'b1;
            end
            row_cyc++;
        end
        // Let the last transfer land, then settle the books for the row
        tick();
        in_valid = 1'b0;
        out_ready = 1'b1;
        absorb_drops();
        dropped = int'(drop_count) - drop_base;
        // Every item has left, so the chain must be empty now
        check_count(16'(out_valid), 16'd0, "out_valid");
        check_count(16'(int'(delivered_count) - dc_base + dropped), r.count,
                    "delivered_plus_dropped");
        if (r.outcome == EXP_DROP) begin
            if (dropped == 0) begin
                $display("Output was held long enough but no item was dropped");
                stop_with_failure();
            end
        end else begin
            check_count(16'(dropped), 16'd0, "drop_count_delta");
            if ((r.outcome == EXP_FULL) && !full_seen) begin
                $display("in_ready never fell while the output was held");
                stop_with_failure();
            end
        end
    endtask

    // Run limit
    initial begin
        int limit;
        limit = timeout_limit();
        repeat (limit) @(posedge clk);
        $display("Timeout, run did not finish within %0d cycles", limit);
        stop_with_failure();
    end

    initial begin
        logic [31:0] seed_val;
        row_t        r;
        seed_val = $urandom(32'hc3d3_dcd6);
        rst = 1'b1;
        in_item = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        cyc = 0;
        drops_seen = 0;
        total_delivered = 0;
        max_seen = '0;
        repeat (2) @(posedge clk);
        tick();
        rst = 1'b0;

        // State right after reset
        check_count(16'(out_valid), 16'd0, "out_valid");
        check_count(16'(in_ready), 16'd1, "in_ready");
        check_count(drop_count, 16'd0, "drop_count");
        check_count(delivered_count, 16'd0, "delivered_count");
        check_count(16'(max_age), 16'd0, "max_age");

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = table_row(i);
            run_row(r);
        end

        // Statistics against what was seen at the output
        tick();
        tick();
        check_count(delivered_count, 16'(total_delivered), "delivered_count");
        check_count(16'(max_age), 16'(max_seen), "max_age");
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/age_pipe_pkg.sv
hdl/skid_stage.sv
hdl/age_limit_filter.sv
hdl/delivery_stats.sv
hdl/age_pipe_top.sv
test/age_pipe_tb.sv
